/* verilog/dispatch_pkg.sv */
/*
  dispatch port allocator shared definitions
  port group sizes, per-bundle issue limits and the one-hot
  rotation pointer used by the memory and shift groups
*/

package dispatch_pkg;

  // ports in one rotating group (memory 0-2, shift 6-8)
  localparam int group_ports = 3;

  // all issue ports
  localparam int num_ports = 9;

  // memory list entries that can issue, ports 0-5
  localparam int mem_ports = 6;

  // per-bundle limits
  localparam int max_stores = 3;
  localparam int max_shifts = 3;

  // bit r set means the group is rotated by r
  typedef logic [group_ports-1:0] rot_t;

  localparam rot_t rot_reset = 3'b001;

endpackage

/* verilog/slot_rank_pick.sv */
/*
  slot rank picker
  one-hot positions of the first set bits of a slot mask,
  in ascending slot order, plus the population count
*/

`timescale 1ns/1ps

module slot_rank_pick #(
  parameter int bundle_w = 10,
  parameter int picks = 6
) (
  input  logic [bundle_w-1:0]          mask,
  output logic [bundle_w-1:0]          rank_pos0,
  output logic [bundle_w-1:0]          rank_pos1,
  output logic [bundle_w-1:0]          rank_pos2,
  output logic [bundle_w-1:0]          rank_pos3,
  output logic [bundle_w-1:0]          rank_pos4,
  output logic [bundle_w-1:0]          rank_pos5,
  output logic [$clog2(bundle_w+1)-1:0] count
);

  logic [5:0][bundle_w-1:0] pos;

  // running count of set bits below the current slot
  always_comb begin
    logic [$clog2(bundle_w+1)-1:0] run;
    run = '0;
    pos = '1;
    for (int k = 0; k < bundle_w; k++) begin
      if (mask[k]) begin
        for (int j = 0; j < picks; j++) begin
          if (run == j) begin
            pos[j] = '0;
            pos[j][k] = 1'b1;
          end
        end
        run = run + 1'b1;
      end
    end
    count = run;
  end

  assign rank_pos0 = pos[0];
  assign rank_pos1 = pos[1];
  assign rank_pos2 = pos[2];
  assign rank_pos3 = pos[3];
  assign rank_pos4 = pos[4];
  assign rank_pos5 = pos[5];

endmodule

/* verilog/mem_port_picker.sv */
/*
  memory port picker
  builds the ordered memory list, first stores then loads,
  and reports the store flags and the number of loads placed
*/

`timescale 1ns/1ps

module mem_port_picker #(
  parameter int bundle_w = 10
) (
  input  logic [bundle_w-1:0] load,
  input  logic [bundle_w-1:0] store,
  output logic [bundle_w-1:0] mem_pos0,
  output logic [bundle_w-1:0] mem_pos1,
  output logic [bundle_w-1:0] mem_pos2,
  output logic [bundle_w-1:0] mem_pos3,
  output logic [bundle_w-1:0] mem_pos4,
  output logic [bundle_w-1:0] mem_pos5,
  output logic                mem_is_store0,
  output logic                mem_is_store1,
  output logic                mem_is_store2,
  output logic [2:0]          load_issued
);

  localparam int cnt_w = $clog2(bundle_w + 1);

  logic [2:0][bundle_w-1:0] st_pos;
  logic [5:0][bundle_w-1:0] ld_pos;
  logic [5:0][bundle_w-1:0] list;
  logic [cnt_w-1:0]         st_cnt;
  logic [cnt_w-1:0]         ld_cnt;
  logic [1:0]               n_st;
  logic [2:0]               room;

  slot_rank_pick #(.bundle_w(bundle_w), .picks(dispatch_pkg::max_stores)) store_rank (
    .mask      (store),
    .rank_pos0 (st_pos[0]),
    .rank_pos1 (st_pos[1]),
    .rank_pos2 (st_pos[2]),
    .rank_pos3 (),
    .rank_pos4 (),
    .rank_pos5 (),
    .count     (st_cnt)
  );

  slot_rank_pick #(.bundle_w(bundle_w), .picks(dispatch_pkg::mem_ports)) load_rank (
    .mask      (load),
    .rank_pos0 (ld_pos[0]),
    .rank_pos1 (ld_pos[1]),
    .rank_pos2 (ld_pos[2]),
    .rank_pos3 (ld_pos[3]),
    .rank_pos4 (ld_pos[4]),
    .rank_pos5 (ld_pos[5]),
    .count     (ld_cnt)
  );

  // stores beyond the third are dropped, loads slide up behind them
  always_comb begin
    n_st = (st_cnt > dispatch_pkg::max_stores) ? 2'(dispatch_pkg::max_stores) : st_cnt[1:0];
    list = '1;
    for (int i = 0; i < dispatch_pkg::mem_ports; i++) begin
      if (i >= n_st) begin
        list[i] = ld_pos[i - n_st];
      end
    end
    for (int i = 0; i < dispatch_pkg::max_stores; i++) begin
      if (i < n_st) begin
        list[i] = st_pos[i];
      end
    end
    room = 3'(dispatch_pkg::mem_ports) - 3'(n_st);
    load_issued = (ld_cnt > room) ? room : 3'(ld_cnt);
  end

  assign mem_pos0 = list[0];
  assign mem_pos1 = list[1];
  assign mem_pos2 = list[2];
  assign mem_pos3 = list[3];
  assign mem_pos4 = list[4];
  assign mem_pos5 = list[5];

  assign mem_is_store0 = (n_st > 2'd0);
  assign mem_is_store1 = (n_st > 2'd1);
  assign mem_is_store2 = (n_st > 2'd2);

endmodule

/* verilog/arith_port_picker.sv */
/*
  arithmetic port picker
  ranks the shift and ALU slots of a bundle and counts
  the shifts that fit in the shift group
*/

`timescale 1ns/1ps

module arith_port_picker #(
  parameter int bundle_w = 10
) (
  input  logic [bundle_w-1:0] alu,
  input  logic [bundle_w-1:0] shift,
  output logic [bundle_w-1:0] shift_pos0,
  output logic [bundle_w-1:0] shift_pos1,
  output logic [bundle_w-1:0] shift_pos2,
  output logic [bundle_w-1:0] alu_pos0,
  output logic [bundle_w-1:0] alu_pos1,
  output logic [bundle_w-1:0] alu_pos2,
  output logic [bundle_w-1:0] alu_pos3,
  output logic [bundle_w-1:0] alu_pos4,
  output logic [bundle_w-1:0] alu_pos5,
  output logic [1:0]          shift_issued
);

  localparam int cnt_w = $clog2(bundle_w + 1);

  logic [cnt_w-1:0] sh_cnt;

  // shift entry 0 is the oldest shift and lands on port 8
  slot_rank_pick #(.bundle_w(bundle_w), .picks(dispatch_pkg::max_shifts)) shift_rank (
    .mask      (shift),
    .rank_pos0 (shift_pos0),
    .rank_pos1 (shift_pos1),
    .rank_pos2 (shift_pos2),
    .rank_pos3 (),
    .rank_pos4 (),
    .rank_pos5 (),
    .count     (sh_cnt)
  );

  // at most six free ports exist for ALU ops
  slot_rank_pick #(.bundle_w(bundle_w), .picks(6)) alu_rank (
    .mask      (alu),
    .rank_pos0 (alu_pos0),
    .rank_pos1 (alu_pos1),
    .rank_pos2 (alu_pos2),
    .rank_pos3 (alu_pos3),
    .rank_pos4 (alu_pos4),
    .rank_pos5 (alu_pos5),
    .count     ()
  );

  // extra shifts wait for a later bundle
  always_comb begin
    if (sh_cnt > dispatch_pkg::max_shifts) begin
      shift_issued = 2'(dispatch_pkg::max_shifts);
    end else begin
      shift_issued = sh_cnt[1:0];
    end
  end

endmodule

/* verilog/issue_port_merge.sv */
/*
  issue port merge
  places memory, shift and ALU entries on the nine ports, rotates
  the memory and shift groups and keeps both rotation pointers
*/

`timescale 1ns/1ps

module issue_port_merge #(
  parameter int bundle_w = 10
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic [bundle_w-1:0] mem_pos0,
  input  logic [bundle_w-1:0] mem_pos1,
  input  logic [bundle_w-1:0] mem_pos2,
  input  logic [bundle_w-1:0] mem_pos3,
  input  logic [bundle_w-1:0] mem_pos4,
  input  logic [bundle_w-1:0] mem_pos5,
  input  logic                mem_is_store0,
  input  logic                mem_is_store1,
  input  logic                mem_is_store2,
  input  logic [2:0]          load_issued,
  input  logic [bundle_w-1:0] shift_pos0,
  input  logic [bundle_w-1:0] shift_pos1,
  input  logic [bundle_w-1:0] shift_pos2,
  input  logic [bundle_w-1:0] alu_pos0,
  input  logic [bundle_w-1:0] alu_pos1,
  input  logic [bundle_w-1:0] alu_pos2,
  input  logic [bundle_w-1:0] alu_pos3,
  input  logic [bundle_w-1:0] alu_pos4,
  input  logic [bundle_w-1:0] alu_pos5,
  input  logic [1:0]          shift_issued,
  output logic [bundle_w-1:0] pos0,
  output logic [bundle_w-1:0] pos1,
  output logic [bundle_w-1:0] pos2,
  output logic [bundle_w-1:0] pos3,
  output logic [bundle_w-1:0] pos4,
  output logic [bundle_w-1:0] pos5,
  output logic [bundle_w-1:0] pos6,
  output logic [bundle_w-1:0] pos7,
  output logic [bundle_w-1:0] pos8,
  output logic                sto0,
  output logic                sto1,
  output logic                sto2
);

  localparam int gp = dispatch_pkg::group_ports;

  dispatch_pkg::rot_t mem_rot;
  dispatch_pkg::rot_t sh_rot;

  logic [dispatch_pkg::num_ports-1:0][bundle_w-1:0] lp;
  logic [dispatch_pkg::num_ports-1:0][bundle_w-1:0] pp;
  logic [5:0][bundle_w-1:0]                         alu_q;
  logic [gp-1:0]                                    st_log;
  logic [gp-1:0]                                    st_phys;

  // logical group offset shown on physical offset p
  function automatic int src_of(input int p, input dispatch_pkg::rot_t ptr);
    int src;
    src = p;
    for (int r = 0; r < gp; r++) begin
      if (ptr[r]) src = (p + gp - r) % gp;
    end
    return src;
  endfunction

  function automatic dispatch_pkg::rot_t advance(input dispatch_pkg::rot_t ptr,
                                                 input logic [2:0] n);
    case (n % gp)
      1:       return {ptr[gp-2:0], ptr[gp-1]};
      2:       return {ptr[0], ptr[gp-1:1]};
      default: return ptr;
    endcase
  endfunction

  assign alu_q = {alu_pos5, alu_pos4, alu_pos3, alu_pos2, alu_pos1, alu_pos0};
  assign st_log = {mem_is_store2, mem_is_store1, mem_is_store0};

  // free-port test happens before rotation
  always_comb begin
    logic [2:0] n;
    lp = {shift_pos0, shift_pos1, shift_pos2, mem_pos5, mem_pos4,
          mem_pos3, mem_pos2, mem_pos1, mem_pos0};
    n = '0;
    for (int p = 3; p < dispatch_pkg::num_ports; p++) begin
      if (&lp[p]) begin
        lp[p] = alu_q[n];
        n = n + 1'b1;
      end
    end
  end

  // ports 3-5 stay in place
  always_comb begin
    pp = lp;
    for (int p = 0; p < gp; p++) begin
      pp[p] = lp[src_of(p, mem_rot)];
      pp[6 + p] = lp[6 + src_of(p, sh_rot)];
      st_phys[p] = st_log[src_of(p, mem_rot)];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rot <= dispatch_pkg::rot_reset;
      sh_rot <= dispatch_pkg::rot_reset;
    end else if (!stall) begin
      mem_rot <= advance(mem_rot, load_issued);
      sh_rot <= advance(sh_rot, {1'b0, shift_issued});
    end
  end

  assign {pos2, pos1, pos0} = {pp[2], pp[1], pp[0]};
  assign {pos5, pos4, pos3} = {pp[5], pp[4], pp[3]};
  assign {pos8, pos7, pos6} = {pp[8], pp[7], pp[6]};
  assign {sto2, sto1, sto0} = st_phys;

endmodule

/* verilog/dispatch_top.sv */
/*
  dispatch port allocator top
  assigns the slots of one bundle to nine issue ports
*/

`timescale 1ns/1ps

module dispatch_top #(
  parameter int bundle_w = 10
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic [bundle_w-1:0] load,
  input  logic [bundle_w-1:0] store,
  input  logic [bundle_w-1:0] alu,
  input  logic [bundle_w-1:0] shift,
  output logic [bundle_w-1:0] pos0,
  output logic [bundle_w-1:0] pos1,
  output logic [bundle_w-1:0] pos2,
  output logic [bundle_w-1:0] pos3,
  output logic [bundle_w-1:0] pos4,
  output logic [bundle_w-1:0] pos5,
  output logic [bundle_w-1:0] pos6,
  output logic [bundle_w-1:0] pos7,
  output logic [bundle_w-1:0] pos8,
  output logic                sto0,
  output logic                sto1,
  output logic                sto2
);

  logic [bundle_w-1:0] mem_pos0, mem_pos1, mem_pos2;
  logic [bundle_w-1:0] mem_pos3, mem_pos4, mem_pos5;
  logic                mem_is_store0, mem_is_store1, mem_is_store2;
  logic [2:0]          load_issued;
  logic [bundle_w-1:0] shift_pos0, shift_pos1, shift_pos2;
  logic [bundle_w-1:0] alu_pos0, alu_pos1, alu_pos2;
  logic [bundle_w-1:0] alu_pos3, alu_pos4, alu_pos5;
  logic [1:0]          shift_issued;

  mem_port_picker #(.bundle_w(bundle_w)) mem_pick (
    .load, .store,
    .mem_pos0, .mem_pos1, .mem_pos2, .mem_pos3, .mem_pos4, .mem_pos5,
    .mem_is_store0, .mem_is_store1, .mem_is_store2,
    .load_issued
  );

  arith_port_picker #(.bundle_w(bundle_w)) arith_pick (
    .alu, .shift,
    .shift_pos0, .shift_pos1, .shift_pos2,
    .alu_pos0, .alu_pos1, .alu_pos2, .alu_pos3, .alu_pos4, .alu_pos5,
    .shift_issued
  );

  issue_port_merge #(.bundle_w(bundle_w)) merge (
    .clk, .rst, .stall,
    .mem_pos0, .mem_pos1, .mem_pos2, .mem_pos3, .mem_pos4, .mem_pos5,
    .mem_is_store0, .mem_is_store1, .mem_is_store2,
    .load_issued,
    .shift_pos0, .shift_pos1, .shift_pos2,
    .alu_pos0, .alu_pos1, .alu_pos2, .alu_pos3, .alu_pos4, .alu_pos5,
    .shift_issued,
    .pos0, .pos1, .pos2, .pos3, .pos4, .pos5, .pos6, .pos7, .pos8,
    .sto0, .sto1, .sto2
  );

endmodule

/* tb/tb_clock.sv */
/*
  testbench clock source
  free-running clock with a configurable period
*/

`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(period_ns / 2.0);
    clk = ~clk;
  end

endmodule

/* tb/dispatch_tb.sv */
/*
  testbench for the dispatch port allocator
  directed and random bundles, each cycle checked against a
  model of the allocation and rotation rules
*/

`timescale 1ns/1ps

module dispatch_tb;

  localparam int bundle_w = 10;
  // the tests take about 250 cycles
  localparam int max_cycles = 2000;
  localparam logic [bundle_w-1:0] none = '1;

  logic                    clk;
  logic                    rst;
  logic                    stall;
  logic [bundle_w-1:0]     load;
  logic [bundle_w-1:0]     store;
  logic [bundle_w-1:0]     alu;
  logic [bundle_w-1:0]     shift;
  wire [8:0][bundle_w-1:0] got;
  wire [2:0]               sto_got;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  // model copies of the memory and shift rotation
  int mem_r = 0;
  int sh_r = 0;

  tb_clock #(.period_ns(20)) clk_gen (.clk);

  dispatch_top #(.bundle_w(bundle_w)) dut0 (
    .clk, .rst, .stall, .load, .store, .alu, .shift,
    .pos0(got[0]), .pos1(got[1]), .pos2(got[2]),
    .pos3(got[3]), .pos4(got[4]), .pos5(got[5]),
    .pos6(got[6]), .pos7(got[7]), .pos8(got[8]),
    .sto0(sto_got[0]), .sto1(sto_got[1]), .sto2(sto_got[2])
  );

  function automatic logic [bundle_w-1:0] slot_bit(input int k);
    logic [bundle_w-1:0] v;
    v = '0;
    v[k] = 1'b1;
    return v;
  endfunction

  function automatic dispatch_pkg::rot_t rot_of(input int r);
    dispatch_pkg::rot_t v;
    v = '0;
    v[r] = 1'b1;
    return v;
  endfunction

  // probe has stores in slots 0-2, so slot 0 marks logical entry 0
  function automatic dispatch_pkg::rot_t mem_rot_seen();
    dispatch_pkg::rot_t v;
    v = '0;
    for (int p = 0; p < 3; p++) begin
      if (got[p] === slot_bit(0)) v[p] = 1'b1;
    end
    return v;
  endfunction

  task automatic check_pos(input int port, input logic [bundle_w-1:0] exp,
                           input logic [bundle_w-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t pos%0d expected %b got %b", $time, port, exp, act);
    end
  endtask

  task automatic check_sto(input int port, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t sto%0d expected %b got %b", $time, port, exp, act);
    end
  endtask

  task automatic check_rot(input dispatch_pkg::rot_t exp, input dispatch_pkg::rot_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t memory pointer expected %b got %b", $time, exp, act);
    end
  endtask

  // reference allocation for the current model pointers
  task automatic model_ports(input logic [bundle_w-1:0] ld, input logic [bundle_w-1:0] st,
                             input logic [bundle_w-1:0] al, input logic [bundle_w-1:0] sh,
                             output logic [8:0][bundle_w-1:0] ep, output logic [2:0] es,
                             output int n_ld, output int n_sh);
    int mem_q[$];
    int sh_q[$];
    int n_st;
    int a;
    logic [8:0][bundle_w-1:0] lg;
    n_st = 0;
    for (int k = 0; k < bundle_w; k++) begin
      if (st[k] && n_st < 3) begin
        mem_q.push_back(k);
        n_st++;
      end
    end
    for (int k = 0; k < bundle_w; k++) begin
      if (ld[k]) mem_q.push_back(k);
      if (sh[k] && sh_q.size() < 3) sh_q.push_back(k);
    end
    lg = '1;
    for (int i = 0; i < 6 && i < mem_q.size(); i++) begin
      lg[i] = slot_bit(mem_q[i]);
    end
    for (int i = 0; i < sh_q.size(); i++) begin
      lg[8 - i] = slot_bit(sh_q[i]);
    end
    // ALU ops take the free ports 3 to 8 in ascending order
    a = 0;
    for (int p = 3; p < 9; p++) begin
      if (lg[p] == none) begin
        while (a < bundle_w && !al[a]) a++;
        if (a < bundle_w) begin
          lg[p] = slot_bit(a);
          a++;
        end
      end
    end
    ep = lg;
    for (int i = 0; i < 3; i++) begin
      ep[(i + mem_r) % 3] = lg[i];
      ep[6 + (i + sh_r) % 3] = lg[6 + i];
      es[(i + mem_r) % 3] = (i < n_st);
    end
    n_ld = ((mem_q.size() > 6) ? 6 : mem_q.size()) - n_st;
    n_sh = sh_q.size();
  endtask

  task automatic apply_bundle(input logic [bundle_w-1:0] ld, input logic [bundle_w-1:0] st,
                              input logic [bundle_w-1:0] al, input logic [bundle_w-1:0] sh,
                              input logic stl);
    logic [8:0][bundle_w-1:0] ep;
    logic [2:0] es;
    int n_ld;
    int n_sh;
    @(posedge clk);
    load <= ld;
    store <= st;
    alu <= al;
    shift <= sh;
    stall <= stl;
    @(negedge clk);
    model_ports(ld, st, al, sh, ep, es, n_ld, n_sh);
    for (int p = 0; p < 9; p++) begin
      check_pos(p, ep[p], got[p]);
    end
    for (int s = 0; s < 3; s++) begin
      check_sto(s, es[s], sto_got[s]);
    end
    // pointers move on the coming edge unless stalled
    if (!stl) begin
      mem_r = (mem_r + n_ld) % 3;
      sh_r = (sh_r + n_sh) % 3;
    end
  endtask

  task automatic do_reset();
    @(posedge clk);
    rst <= 1'b1;
    stall <= 1'b0;
    load <= '0;
    store <= '0;
    alu <= '0;
    shift <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    mem_r = 0;
    sh_r = 0;
  endtask

  task automatic mem_order_after_reset();
    do_reset();
    apply_bundle(10'b0010100110, 10'b0000001001, '0, '0, 1'b0);
    check_pos(0, slot_bit(0), got[0]);
    check_pos(1, slot_bit(3), got[1]);
    check_pos(2, slot_bit(1), got[2]);
    check_pos(3, slot_bit(2), got[3]);
    check_pos(4, slot_bit(5), got[4]);
    check_pos(5, slot_bit(7), got[5]);
    for (int p = 6; p < 9; p++) begin
      check_pos(p, none, got[p]);
    end
    check_sto(0, 1'b1, sto_got[0]);
    check_sto(1, 1'b1, sto_got[1]);
    check_sto(2, 1'b0, sto_got[2]);
  endtask

  task automatic store_shift_limits();
    int want[9];
    want = '{0, 2, 4, -1, -1, -1, 5, 3, 1};
    do_reset();
    apply_bundle('0, 10'b0101010101, '0, 10'b0010101010, 1'b0);
    for (int p = 0; p < 9; p++) begin
      check_pos(p, (want[p] < 0) ? none : slot_bit(want[p]), got[p]);
    end
    for (int s = 0; s < 3; s++) begin
      check_sto(s, 1'b1, sto_got[s]);
    end
  endtask

  task automatic alu_fill();
    int want[9];
    want = '{0, 2, 4, 6, 5, 7, 8, 3, 1};
    do_reset();
    apply_bundle(10'b0001010101, '0, 10'b1110100000, 10'b0000001010, 1'b0);
    for (int p = 0; p < 9; p++) begin
      check_pos(p, slot_bit(want[p]), got[p]);
    end
    apply_bundle('0, '0, '0, '0, 1'b0);
    for (int p = 0; p < 9; p++) begin
      check_pos(p, none, got[p]);
    end
  endtask

  task automatic rotation_and_stall();
    do_reset();
    apply_bundle(10'b0000001111, '0, '0, '0, 1'b0);
    apply_bundle('0, 10'b0000000111, '0, '0, 1'b0);
    check_rot(rot_of(1), mem_rot_seen());
    apply_bundle(10'b0000001111, '0, '0, '0, 1'b1);
    apply_bundle('0, 10'b0000000111, '0, '0, 1'b0);
    check_rot(rot_of(1), mem_rot_seen());
  endtask

  task automatic shift_rotation();
    do_reset();
    apply_bundle('0, '0, '0, 10'b0000000011, 1'b0);
    // offset (2 + 2) mod 3 is port 7
    apply_bundle('0, '0, '0, 10'b0000000100, 1'b0);
    check_pos(7, slot_bit(2), got[7]);
  endtask

  task automatic random_bundles();
    logic [bundle_w-1:0] ld;
    logic [bundle_w-1:0] st;
    logic [bundle_w-1:0] al;
    logic [bundle_w-1:0] sh;
    int kind;
    for (int n = 0; n < 200; n++) begin
      ld = '0;
      st = '0;
      al = '0;
      sh = '0;
      // one class per slot keeps the masks disjoint
      for (int k = 0; k < bundle_w; k++) begin
        kind = $urandom % 5;
        case (kind)
          1: ld[k] = 1'b1;
          2: st[k] = 1'b1;
          3: al[k] = 1'b1;
          4: sh[k] = 1'b1;
          default: ;
        endcase
      end
      apply_bundle(ld, st, al, sh, ($urandom % 4) == 0);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    stall = 1'b0;
    load = '0;
    store = '0;
    alu = '0;
    shift = '0;
    void'($urandom(32'h6671_aa05));
    mem_order_after_reset();
    store_shift_limits();
    alu_fill();
    rotation_and_stall();
    shift_rotation();
    random_bundles();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* project.f */
verilog/dispatch_pkg.sv
verilog/slot_rank_pick.sv
verilog/mem_port_picker.sv
verilog/arith_port_picker.sv
verilog/issue_port_merge.sv
verilog/dispatch_top.sv
tb/tb_clock.sv
tb/dispatch_tb.sv

/* Bender.yml */
package:
  name: dispatch_alloc

sources:
  - files:
      - verilog/dispatch_pkg.sv
      - verilog/slot_rank_pick.sv
      - verilog/mem_port_picker.sv
      - verilog/arith_port_picker.sv
      - verilog/issue_port_merge.sv
      - verilog/dispatch_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/dispatch_tb.sv
